/* hdl/cpuSettings.svh */
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// Datapath and address width in bits
`define CPU_XLEN 64

// Architectural registers, the last one is XZR
`define CPU_REG_COUNT 32

// Fetch address after reset
`define CPU_RESET_PC 64'd0

`endif

/* hdl/cpuPkg.sv */
`include "cpuSettings.svh"

package cpuPkg;

   typedef logic [`CPU_XLEN-1:0] dwordT;
   typedef logic [31:0] instrT;
   typedef logic [$clog2(`CPU_REG_COUNT)-1:0] regIdxT;

   // Opcode patterns, don't-care low bits of each format held at zero
   typedef enum logic [10:0] {
      OP_NOP   = 11'b00000000000,
      OP_ADDI  = 11'b10010001000,
      OP_ADDS  = 11'b10101011000,
      OP_SUBS  = 11'b11101011000,
      OP_AND   = 11'b10001010000,
      OP_ORR   = 11'b10101010000,
      OP_EOR   = 11'b11001010000,
      OP_LDUR  = 11'b11111000010,
      OP_STUR  = 11'b11111000000,
      OP_LDURB = 11'b00111000010,
      OP_STURB = 11'b00111000000,
      OP_MOVZ  = 11'b11010010100,
      OP_MOVK  = 11'b11110010100,
      OP_B     = 11'b00010100000,
      OP_CBZ   = 11'b10110100000,
      OP_BCOND = 11'b01010100000
   } opcodeT;

   typedef enum logic [2:0] {
      ALU_ADD   = 3'd0,
      ALU_SUB   = 3'd1,
      ALU_AND   = 3'd2,
      ALU_ORR   = 3'd3,
      ALU_EOR   = 3'd4,
      ALU_PASSB = 3'd5
   } aluFnT;

   typedef struct packed {
      regIdxT     rd;
      regIdxT     rn;
      regIdxT     rm;
      logic       regWrite;
      logic       aluSrcImm;
      aluFnT      aluFn;
      logic       setFlags;
      logic       memRead;
      logic       memWrite;
      logic       byteXfer;
      logic       isMovz;
      logic       isMovk;
      logic [1:0] movShift;
      logic       branch;
      logic       condBranch;
      logic       cbz;
      logic       bLt;
   } ctrlT;

   typedef struct packed {
      dwordT aluImm;
      dwordT brOffset;
   } immT;

   typedef struct packed {
      logic n;
      logic z;
      logic v;
      logic c;
   } flagsT;

   typedef struct packed {
      dwordT addr;
      dwordT wrData;
      logic  write;
      logic  read;
      logic  byteXfer;
   } memReqT;

endpackage

/* hdl/instrDecode.sv */
`timescale 1ns/1ps

module instrDecode (
   input  cpuPkg::instrT instruction,
   output cpuPkg::ctrlT  ctrl,
   output cpuPkg::immT   imm
);
   import cpuPkg::*;

   localparam int xlen = $bits(dwordT);

   logic [10:0] op;
   opcodeT      opc;
   regIdxT      rdIdx;
   regIdxT      rnIdx;
   regIdxT      rmIdx;
   logic [8:0]  daddr9;
   logic [11:0] imm12;
   logic [15:0] imm16;
   logic [18:0] condAddr19;
   logic [25:0] brAddr26;
   logic        condIsLt;

   // Instruction fields
   assign op         = instruction[31:21];
   assign rdIdx      = instruction[4:0];
   assign rnIdx      = instruction[9:5];
   assign rmIdx      = instruction[20:16];
   assign daddr9     = instruction[20:12];
   assign imm12      = instruction[21:10];
   assign imm16      = instruction[20:5];
   assign condAddr19 = instruction[23:5];
   assign brAddr26   = instruction[25:0];
   assign condIsLt   = (instruction[4:0] == 5'h0B);

   // Widest formats first so short patterns never shadow full opcodes
   always_comb begin
      opc = OP_NOP;
      if (op inside {OP_ADDS, OP_SUBS, OP_AND, OP_ORR, OP_EOR,
                     OP_LDUR, OP_STUR, OP_LDURB, OP_STURB}) begin
         opc = opcodeT'(op);
      end else if ({op[10:1], 1'b0} == OP_ADDI) begin
         opc = OP_ADDI;
      end else if ({op[10:2], 2'b00} inside {OP_MOVZ, OP_MOVK}) begin
         opc = opcodeT'({op[10:2], 2'b00});
      end else if ({op[10:3], 3'b000} == OP_CBZ) begin
         opc = OP_CBZ;
      end else if ({op[10:3], 3'b000} == OP_BCOND && condIsLt) begin
         opc = OP_BCOND;
      end else if ({op[10:5], 5'b00000} == OP_B) begin
         opc = OP_B;
      end
   end

   always_comb begin
      ctrl          = '0;
      ctrl.rd       = rdIdx;
      ctrl.rn       = rnIdx;
      ctrl.rm       = rmIdx;
      ctrl.aluFn    = ALU_ADD;
      ctrl.movShift = instruction[22:21];
      case (opc)
         OP_ADDI: begin
            ctrl.regWrite  = 1'b1;
            ctrl.aluSrcImm = 1'b1;
         end
         OP_ADDS: begin
            ctrl.regWrite = 1'b1;
            ctrl.setFlags = 1'b1;
         end
         OP_SUBS: begin
            ctrl.regWrite = 1'b1;
            ctrl.setFlags = 1'b1;
            ctrl.aluFn    = ALU_SUB;
         end
         OP_AND: begin
            ctrl.regWrite = 1'b1;
            ctrl.aluFn    = ALU_AND;
         end
         OP_ORR: begin
            ctrl.regWrite = 1'b1;
            ctrl.aluFn    = ALU_ORR;
         end
         OP_EOR: begin
            ctrl.regWrite = 1'b1;
            ctrl.aluFn    = ALU_EOR;
         end
         OP_LDUR, OP_LDURB: begin
            ctrl.regWrite  = 1'b1;
            ctrl.aluSrcImm = 1'b1;
            ctrl.memRead   = 1'b1;
            ctrl.byteXfer  = (opc == OP_LDURB);
         end
         OP_STUR, OP_STURB: begin
            ctrl.rm        = rdIdx;
            ctrl.aluSrcImm = 1'b1;
            ctrl.memWrite  = 1'b1;
            ctrl.byteXfer  = (opc == OP_STURB);
         end
         OP_MOVZ: begin
            ctrl.regWrite  = 1'b1;
            ctrl.aluSrcImm = 1'b1;
            ctrl.aluFn     = ALU_PASSB;
            ctrl.isMovz    = 1'b1;
         end
         OP_MOVK: begin
            // Old Rd value comes in on the second port for the merge
            ctrl.rm       = rdIdx;
            ctrl.regWrite = 1'b1;
            ctrl.aluFn    = ALU_PASSB;
            ctrl.isMovk   = 1'b1;
         end
         OP_B: begin
            ctrl.branch = 1'b1;
         end
         OP_CBZ: begin
            ctrl.rm         = rdIdx;
            ctrl.condBranch = 1'b1;
            ctrl.cbz        = 1'b1;
         end
         OP_BCOND: begin
            ctrl.condBranch = 1'b1;
            ctrl.bLt        = 1'b1;
         end
         default: begin
         end
      endcase
   end

   always_comb begin
      case (opc)
         OP_ADDI:                             imm.aluImm = dwordT'(imm12);
         OP_LDUR, OP_LDURB, OP_STUR, OP_STURB: imm.aluImm = {{(xlen-9){daddr9[8]}}, daddr9};
         OP_MOVZ, OP_MOVK:                    imm.aluImm = dwordT'(imm16);
         default:                             imm.aluImm = '0;
      endcase
      // Word offsets become byte offsets
      if (opc == OP_B) begin
         imm.brOffset = {{(xlen-28){brAddr26[25]}}, brAddr26, 2'b00};
      end else begin
         imm.brOffset = {{(xlen-21){condAddr19[18]}}, condAddr19, 2'b00};
      end
   end

endmodule

/* hdl/regFile.sv */
`timescale 1ns/1ps
`include "cpuSettings.svh"

module regFile (
   input  logic           clk,
   input  logic           rstN,
   input  cpuPkg::regIdxT rdAddrA,
   input  cpuPkg::regIdxT rdAddrB,
   input  cpuPkg::regIdxT wrAddr,
   input  logic           wrEn,
   input  cpuPkg::dwordT  wrData,
   output cpuPkg::dwordT  rdDataA,
   output cpuPkg::dwordT  rdDataB
);
   import cpuPkg::*;

   // XZR is the highest index and has no storage
   localparam regIdxT zeroReg = regIdxT'(`CPU_REG_COUNT - 1);

   dwordT regs [`CPU_REG_COUNT-1];

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         for (int i = 0; i < `CPU_REG_COUNT - 1; i++) begin
            regs[i] <= '0;
         end
      end else if (wrEn && wrAddr != zeroReg) begin
         regs[wrAddr] <= wrData;
      end
   end

   // Reads see the value from before this cycle's write
   assign rdDataA = (rdAddrA == zeroReg) ? '0 : regs[rdAddrA];
   assign rdDataB = (rdAddrB == zeroReg) ? '0 : regs[rdAddrB];

endmodule

/* hdl/execUnit.sv */
`timescale 1ns/1ps

module execUnit (
   input  logic          clk,
   input  logic          rstN,
   input  cpuPkg::ctrlT  ctrl,
   input  cpuPkg::immT   imm,
   input  cpuPkg::dwordT opA,
   input  cpuPkg::dwordT opB,
   output cpuPkg::dwordT aluResult,
   output cpuPkg::dwordT storeData,
   output cpuPkg::flagsT flags
);
   import cpuPkg::*;

   localparam int xlen = $bits(dwordT);

   dwordT srcB;
   dwordT addend;
   dwordT sum;
   logic  carryOut;
   logic  isSub;
   dwordT aluOut;
   dwordT hwMask;
   dwordT hwPlaced;
   flagsT flagsNext;

   assign srcB  = ctrl.aluSrcImm ? imm.aluImm : opB;
   assign isSub = (ctrl.aluFn == ALU_SUB);

   // A - B done as A + ~B + 1, carry out is then the not-borrow
   assign addend             = isSub ? ~srcB : srcB;
   assign {carryOut, sum}    = {1'b0, opA} + {1'b0, addend} + (xlen+1)'(isSub);

   always_comb begin
      case (ctrl.aluFn)
         ALU_AND:   aluOut = opA & srcB;
         ALU_ORR:   aluOut = opA | srcB;
         ALU_EOR:   aluOut = opA ^ srcB;
         ALU_PASSB: aluOut = srcB;
         default:   aluOut = sum;
      endcase
   end

   // Halfword lane picked by the MOVZ/MOVK shift field
   assign hwMask   = dwordT'(16'hFFFF) << {ctrl.movShift, 4'b0000};
   assign hwPlaced = dwordT'(imm.aluImm[15:0]) << {ctrl.movShift, 4'b0000};

   always_comb begin
      if (ctrl.isMovz) begin
         aluResult = hwPlaced;
      end else if (ctrl.isMovk) begin
         aluResult = (aluOut & ~hwMask) | hwPlaced;
      end else begin
         aluResult = aluOut;
      end
   end

   // Store data and the CBZ test both use the second register port
   assign storeData = opB;

   assign flagsNext.n = sum[xlen-1];
   assign flagsNext.z = (sum == '0);
   assign flagsNext.c = carryOut;
   // Overflow when both inputs agree in sign and the sum does not
   assign flagsNext.v = (opA[xlen-1] == addend[xlen-1]) && (sum[xlen-1] != opA[xlen-1]);

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         flags <= '0;
      end else if (ctrl.setFlags) begin
         flags <= flagsNext;
      end
   end

endmodule

/* hdl/resultStage.sv */
`timescale 1ns/1ps

module resultStage (
   input  cpuPkg::ctrlT   ctrl,
   input  cpuPkg::immT    imm,
   input  cpuPkg::dwordT  pc,
   input  cpuPkg::dwordT  aluResult,
   input  cpuPkg::dwordT  storeData,
   input  cpuPkg::flagsT  flags,
   input  cpuPkg::dwordT  dataRdData,
   output cpuPkg::memReqT dataReq,
   output cpuPkg::dwordT  wbData,
   output cpuPkg::dwordT  nextPc
);
   import cpuPkg::*;

   dwordT loaded;
   dwordT pcPlus4;
   dwordT pcBranch;
   logic  regZero;
   logic  lessThan;
   logic  taken;

   // Address is the base plus Daddr9 from the ALU
   assign dataReq.addr     = aluResult;
   assign dataReq.wrData   = storeData;
   assign dataReq.write    = ctrl.memWrite;
   assign dataReq.read     = ctrl.memRead;
   assign dataReq.byteXfer = ctrl.byteXfer;

   // LDURB zero-extends the low byte
   assign loaded = ctrl.byteXfer ? dwordT'(dataRdData[7:0]) : dataRdData;
   assign wbData = ctrl.memRead ? loaded : aluResult;

   assign regZero  = (storeData == '0);
   // Signed less-than from the last SUBS
   assign lessThan = flags.n ^ flags.v;

   assign taken = ctrl.branch
                | (ctrl.condBranch & ((ctrl.cbz & regZero) | (ctrl.bLt & lessThan)));

   assign pcPlus4  = pc + dwordT'(4);
   assign pcBranch = pc + imm.brOffset;
   assign nextPc   = taken ? pcBranch : pcPlus4;

endmodule

/* hdl/cpu64.sv */
`timescale 1ns/1ps
`include "cpuSettings.svh"

module cpu64 (
   input  logic           clk,
   input  logic           rstN,
   output cpuPkg::dwordT  instrAddr,
   input  cpuPkg::instrT  instruction,
   output cpuPkg::memReqT dataReq,
   input  cpuPkg::dwordT  dataRdData
);
   import cpuPkg::*;

   ctrlT  ctrl;
   immT   imm;
   dwordT rdDataA;
   dwordT rdDataB;
   dwordT aluResult;
   dwordT storeData;
   flagsT flags;
   dwordT wbData;
   dwordT nextPc;
   memReqT memReq;

   // Program counter loads every cycle
   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         instrAddr <= `CPU_RESET_PC;
      end else begin
         instrAddr <= nextPc;
      end
   end

   // No memory strobes while reset is held
   always_comb begin
      dataReq       = memReq;
      dataReq.write = memReq.write & rstN;
      dataReq.read  = memReq.read & rstN;
   end

   instrDecode decode_i (
      .instruction,
      .ctrl,
      .imm
   );

   regFile regs_i (
      .clk,
      .rstN,
      .rdAddrA (ctrl.rn),
      .rdAddrB (ctrl.rm),
      .wrAddr  (ctrl.rd),
      .wrEn    (ctrl.regWrite),
      .wrData  (wbData),
      .rdDataA,
      .rdDataB
   );

   execUnit exec_i (
      .clk,
      .rstN,
      .ctrl,
      .imm,
      .opA (rdDataA),
      .opB (rdDataB),
      .aluResult,
      .storeData,
      .flags
   );

   resultStage result_i (
      .ctrl,
      .imm,
      .pc (instrAddr),
      .aluResult,
      .storeData,
      .flags,
      .dataRdData,
      .dataReq (memReq),
      .wbData,
      .nextPc
   );

endmodule

/* tb/cpuModel.svh */
`ifndef CPU_MODEL_SVH
`define CPU_MODEL_SVH

// Full 11-bit LEGv8 opcode fields
localparam logic [10:0] opAdds  = 11'b10101011000;
localparam logic [10:0] opSubs  = 11'b11101011000;
localparam logic [10:0] opAnd   = 11'b10001010000;
localparam logic [10:0] opOrr   = 11'b10101010000;
localparam logic [10:0] opEor   = 11'b11001010000;
localparam logic [10:0] opLdur  = 11'b11111000010;
localparam logic [10:0] opStur  = 11'b11111000000;
localparam logic [10:0] opLdurb = 11'b00111000010;
localparam logic [10:0] opSturb = 11'b00111000000;

// Architectural state of the reference model
dwordT      mPc;
dwordT      mRegs [32];
logic       mLt;
logic [7:0] mMem [256];

// Memory request that the last stepped instruction should issue
logic  expWrite;
logic  expRead;
logic  expByte;
dwordT expAddr;
dwordT expData;

dwordT rngState;
instrT prog [64];
int    progLen;

// xorshift64
function automatic dwordT nextRandom();
   rngState ^= rngState << 13;
   rngState ^= rngState >> 7;
   rngState ^= rngState << 17;
   return rngState;
endfunction

function automatic int randInt();
   return int'(nextRandom() >> 33);
endfunction

function automatic instrT rFormat(logic [10:0] op, int rd, int rn, int rm);
   return {op, 5'(rm), 6'd0, 5'(rn), 5'(rd)};
endfunction

function automatic instrT addiWord(int rd, int rn, int imm);
   return {10'b1001000100, 12'(imm), 5'(rn), 5'(rd)};
endfunction

function automatic instrT dFormat(logic [10:0] op, int rt, int rn, int off);
   return {op, 9'(off), 2'b00, 5'(rn), 5'(rt)};
endfunction

// MOVK when keep is set, MOVZ otherwise
function automatic instrT movWord(logic keep, int rd, int imm, int hw);
   return {keep ? 9'b111100101 : 9'b110100101, 2'(hw), 16'(imm), 5'(rd)};
endfunction

function automatic instrT bWord(int off);
   return {6'b000101, 26'(off)};
endfunction

// B.LT when isLt is set (cond 0x0B in rt), CBZ otherwise
function automatic instrT cbWord(logic isLt, int rt, int off);
   return {isLt ? 8'b01010100 : 8'b10110100, 19'(off), 5'(rt)};
endfunction

function automatic void emit(instrT word);
   prog[progLen] = word;
   progLen++;
endfunction

// SUBS then B.LT over an ADDI that marks the not-taken path in X18
function automatic void ltBranchCase(int rd, int rn, int rm, int mark);
   emit(rFormat(opSubs, rd, rn, rm));
   emit(cbWord(1'b1, 11, 2));
   emit(addiWord(18, 18, mark));
endfunction

function automatic void buildProgram();
   progLen = 0;
   rngState = 64'd91;
   for (int i = 0; i < 256; i++) begin
      mMem[i] = 8'(nextRandom());
   end
   emit(movWord(1'b0, 1, randInt(), 0));
   for (int hw = 1; hw < 4; hw++) begin
      emit(movWord(1'b1, 1, randInt(), hw));
   end
   emit(movWord(1'b0, 2, randInt(), 1));
   emit(movWord(1'b1, 2, randInt(), 3));
   // Store base and load base
   emit(movWord(1'b0, 20, 128, 0));
   emit(movWord(1'b0, 21, 64, 0));
   emit(addiWord(3, 1, randInt()));
   emit(rFormat(opAdds, 4, 1, 2));
   emit(rFormat(opSubs, 5, 1, 2));
   emit(rFormat(opAnd, 6, 1, 2));
   emit(rFormat(opOrr, 7, 1, 2));
   emit(rFormat(opEor, 8, 1, 2));
   emit(addiWord(31, 1, randInt()));
   for (int r = 3; r <= 8; r++) begin
      emit(dFormat(opStur, r, 20, (r - 3) * 8));
   end
   emit(dFormat(opStur, 31, 20, 48));
   emit(dFormat(opLdur, 9, 21, -8 * (1 + randInt() % 6)));
   emit(dFormat(opLdur, 10, 21, 8 * (randInt() % 7)));
   emit(dFormat(opLdurb, 11, 21, -(1 + randInt() % 60)));
   emit(dFormat(opLdurb, 12, 21, randInt() % 60));
   emit(dFormat(opStur, 9, 20, 56));
   emit(dFormat(opStur, 10, 20, 64));
   // Three byte stores merged into one dword and read back whole
   emit(dFormat(opSturb, 11, 20, 72));
   emit(dFormat(opSturb, 12, 20, 73));
   emit(dFormat(opSturb, 1, 20, 74));
   emit(dFormat(opLdur, 13, 20, 72));
   emit(dFormat(opStur, 13, 20, 80));
   emit(movWord(1'b0, 16, 5, 0));
   emit(movWord(1'b0, 17, 9, 0));
   emit(movWord(1'b0, 22, 16'h8000, 3));
   emit(addiWord(23, 31, 1));
   ltBranchCase(31, 16, 17, 1);
   ltBranchCase(31, 17, 16, 2);
   // Signed overflow in both directions
   ltBranchCase(24, 22, 23, 4);
   ltBranchCase(31, 24, 22, 8);
   ltBranchCase(14, 1, 2, 16);
   emit(dFormat(opStur, 18, 20, 88));
   emit(cbWord(1'b0, 31, 2));
   emit(addiWord(19, 19, 1));
   emit(cbWord(1'b0, 1, 2));
   emit(addiWord(19, 19, 2));
   // Forward jump, forward again, then back into the middle
   emit(bWord(3));
   emit(bWord(3));
   emit(addiWord(19, 19, 4));
   emit(bWord(-2));
   emit(dFormat(opStur, 19, 20, 96));
   emit(bWord(0));
endfunction

function automatic void stepModel(instrT ins);
   dwordT       a;
   dwordT       b;
   dwordT       t;
   dwordT       addr;
   dwordT       res;
   logic [64:0] wide;
   logic        wr;
   longint      brOff;
   a = mRegs[ins[9:5]];
   b = mRegs[ins[20:16]];
   t = mRegs[ins[4:0]];
   addr = a + {{55{ins[20]}}, ins[20:12]};
   res = '0;
   wr = 1'b1;
   expWrite = 1'b0;
   expRead = 1'b0;
   expByte = 1'b0;
   expAddr = '0;
   expData = '0;
   brOff = 4;
   casez (ins[31:21])
      11'b1001000100?: res = a + dwordT'(ins[21:10]);
      opAdds, opSubs: begin
         // Sign of the exact 65-bit result is the signed less-than
         if (ins[31:21] == opSubs) begin
            wide = {a[63], a} - {b[63], b};
         end else begin
            wide = {a[63], a} + {b[63], b};
         end
         res = wide[63:0];
         mLt = wide[64];
      end
      opAnd: res = a & b;
      opOrr: res = a | b;
      opEor: res = a ^ b;
      opLdur: begin
         expRead = 1'b1;
         expAddr = addr;
         for (int i = 0; i < 8; i++) begin
            res[8*i +: 8] = mMem[8'(addr + 64'(i))];
         end
      end
      opLdurb: begin
         expRead = 1'b1;
         expByte = 1'b1;
         expAddr = addr;
         res = dwordT'(mMem[addr[7:0]]);
      end
      opStur, opSturb: begin
         wr = 1'b0;
         expWrite = 1'b1;
         expByte = !ins[31];
         expAddr = addr;
         expData = t;
         // STURB has bit 31 clear and moves a single byte
         for (int i = 0; i < (ins[31] ? 8 : 1); i++) begin
            mMem[8'(addr + 64'(i))] = t[8*i +: 8];
         end
      end
      11'b110100101??: res = dwordT'(ins[20:5]) << (16 * ins[22:21]);
      11'b111100101??: begin
         res = t;
         res[16*ins[22:21] +: 16] = ins[20:5];
      end
      11'b000101?????: begin
         wr = 1'b0;
         brOff = longint'($signed(ins[25:0])) * 4;
      end
      11'b10110100???: begin
         wr = 1'b0;
         if (t == '0) begin
            brOff = longint'($signed(ins[23:5])) * 4;
         end
      end
      11'b01010100???: begin
         wr = 1'b0;
         if (ins[4:0] == 5'h0B && mLt) begin
            brOff = longint'($signed(ins[23:5])) * 4;
         end
      end
      default: wr = 1'b0;
   endcase
   if (wr && ins[4:0] != 5'd31) begin
      mRegs[ins[4:0]] = res;
   end
   mPc = mPc + dwordT'(brOff);
endfunction

`endif

/* tb/cpu64Tb.sv */
`timescale 1ns/1ps
`include "cpuSettings.svh"

module cpu64Tb;
   import cpuPkg::*;

   `include "cpuModel.svh"

   logic       clk;
   logic       rstN;
   dwordT      instrAddr;
   instrT      instruction;
   memReqT     dataReq;
   dwordT      dataRdData;
   logic [7:0] dataMem [256];
   int         memStamp;
   int         cycles;
   int         cycleLimit;

   cpu64 cpu64_i (
      .clk,
      .rstN,
      .instrAddr,
      .instruction,
      .dataReq,
      .dataRdData
   );

   always #2 clk = ~clk;

   task automatic checkEqual(dwordT actual, dwordT expected, string what);
      if (actual !== expected) begin
         $display("MISMATCH at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
         $display("** FAIL **");
         $fatal(1, "%s", what);
      end
   endtask

   // Program fetch on the falling edge once reset is released
   always @(negedge clk) begin
      if (rstN) begin
         instruction <= prog[instrAddr[7:2]];
      end
   end

   // Data memory read follows the address and every write
   always @(dataReq.addr, memStamp) begin
      for (int i = 0; i < 8; i++) begin
         dataRdData[8*i +: 8] = dataMem[8'(dataReq.addr + 64'(i))];
      end
   end

   always @(posedge clk) begin
      if (rstN && dataReq.write) begin
         if (dataReq.byteXfer) begin
            dataMem[dataReq.addr[7:0]] <= dataReq.wrData[7:0];
         end else begin
            for (int i = 0; i < 8; i++) begin
               dataMem[8'(dataReq.addr + 64'(i))] <= dataReq.wrData[8*i +: 8];
            end
         end
         memStamp <= memStamp + 1;
      end
   end

   initial begin
      clk = 1'b0;
      rstN = 1'b0;
      // A store and then a load sit on the bus while reset is held
      instruction = dFormat(opStur, 1, 20, 0);
      buildProgram();
      for (int i = 0; i < 256; i++) begin
         dataMem[i] = mMem[i];
      end
      for (int i = 0; i < 32; i++) begin
         mRegs[i] = '0;
      end
      mPc = `CPU_RESET_PC;
      mLt = 1'b0;
      cycleLimit = progLen * 4 + 20;
      @(posedge clk);
      @(negedge clk);
      instruction = dFormat(opLdur, 9, 21, 8);
      repeat (2) @(posedge clk);
      @(negedge clk);
      rstN = 1'b1;
      instruction = prog[instrAddr[7:2]];
   end

   // Compare against the model on every committing edge
   always @(posedge clk) begin
      if (!rstN) begin
         checkEqual(dwordT'(dataReq.write), '0, "store strobe during reset");
         checkEqual(dwordT'(dataReq.read), '0, "load strobe during reset");
         checkEqual(instrAddr, `CPU_RESET_PC, "fetch address during reset");
      end else if (cycles >= cycleLimit) begin
         $display("Timeout: halt loop not reached after %0d cycles", cycles);
         $display("** FAIL **");
         $fatal(1, "timeout");
      end else begin
         cycles++;
         checkEqual(instrAddr, mPc, "fetch address");
         if (prog[mPc[7:2]] == bWord(0)) begin
            $display("** PASS **");
            $finish;
         end else begin
            stepModel(prog[mPc[7:2]]);
            checkEqual(dwordT'(dataReq.write), dwordT'(expWrite), "store strobe");
            checkEqual(dwordT'(dataReq.read), dwordT'(expRead), "load strobe");
            checkEqual(dwordT'(dataReq.byteXfer), dwordT'(expByte), "byte transfer");
            if (expWrite || expRead) begin
               checkEqual(dataReq.addr, expAddr, "memory address");
            end
            if (expWrite) begin
               checkEqual(dataReq.wrData, expData, "store data");
            end
         end
      end
   end

endmodule

/* all.f */
+incdir+hdl
+incdir+tb
hdl/cpuPkg.sv
hdl/instrDecode.sv
hdl/regFile.sv
hdl/execUnit.sv
hdl/resultStage.sv
hdl/cpu64.sv
tb/cpu64Tb.sv
